// ==== Makefile ====
# Verilator build for the packet front end testbench

SIM      = verilator
TOP      = pkt_comm_tb
FILELIST = pkt_comm_top.f
BUILD    = obj_dir
FLAGS    = --timing --assert --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST)

# A $fatal or failed assertion gives a nonzero exit status
sim:
	$(SIM) --binary $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== hw/pkt_apb_csr.sv ====
//--------------------------------------------------------------------
// APB register block: sticky status, accepted count, config bytes
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_apb_csr (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  pkt_comm_pkg::apb_req_t apb_req,
  output pkt_comm_pkg::apb_rsp_t apb_rsp,
  input  pkt_comm_pkg::cfg_wr_t  cfg_wr,
  input  pkt_comm_pkg::status_t  err_set,
  input  logic                   accept,
  output logic                   error
);
  import pkt_comm_pkg::*;

  status_t                     status;
  logic [31:0]                 count;
  logic [`CFG_BYTES-1:0][7:0]  cfg;

  logic    access;
  logic    wr;
  logic    addr_hit;
  status_t clr;

  assign access = apb_req.psel && apb_req.penable;
  assign wr     = access && apb_req.pwrite;

  // Write-one-to-clear on STATUS
  assign clr = (wr && apb_req.paddr == `REG_STATUS) ? status_t'(apb_req.pwdata[3:0]) : '0;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      status <= '0;
      count  <= '0;
      cfg    <= '0;
    end else begin
      // A new error wins over a clear in the same cycle
      status <= (status & ~clr) | err_set;
      if (accept) count <= count + 1'b1;
      if (cfg_wr.valid) cfg[cfg_wr.idx] <= cfg_wr.data;
    end
  end

  always_comb begin
    addr_hit = 1'b1;
    case (apb_req.paddr)
      `REG_STATUS: apb_rsp.prdata = {28'd0, status};
      `REG_COUNT:  apb_rsp.prdata = count;
      `REG_CFG0:   apb_rsp.prdata = cfg[3:0];
      `REG_CFG1:   apb_rsp.prdata = cfg[7:4];
      default: begin
        apb_rsp.prdata = '0;
        addr_hit       = 1'b0;
      end
    endcase
  end

  // No wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !addr_hit;

  assign error = |status;

endmodule

// ==== hw/pkt_byte_fifo.sv ====
//--------------------------------------------------------------------
// Input byte FIFO, stores each stream byte with its tlast flag
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_byte_fifo (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  logic [7:0]             s_tdata,
  input  logic                   s_tvalid,
  output logic                   s_tready,
  input  logic                   s_tlast,
  output pkt_comm_pkg::in_byte_t head,
  output logic                   empty,
  input  logic                   pop
);
  import pkt_comm_pkg::*;

  localparam int AW = $clog2(`IN_FIFO_DEPTH);

  in_byte_t    mem [`IN_FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        push;

  // Extra pointer bit tells full from empty
  assign empty    = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign s_tready = ~full;
  assign push     = s_tvalid & s_tready;
  assign head     = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= '{last: s_tlast, data: s_tdata};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== hw/pkt_comm_config.svh ====
//--------------------------------------------------------------------
// Packet front end constants: version, FIFO depths, header and
// payload limits, APB register map
//--------------------------------------------------------------------
`ifndef PKT_COMM_CONFIG_SVH
`define PKT_COMM_CONFIG_SVH

// Protocol
`define PKT_VERSION     8'd2
`define HDR_BYTES       8
`define PKT_LEN_MAX     1024

// Buffering
`define IN_FIFO_DEPTH   64
`define OUT_QUEUE_DEPTH 8
`define CFG_BYTES       8

// APB register map
`define REG_STATUS      8'h00
`define REG_COUNT       8'h04
`define REG_CFG0        8'h10
`define REG_CFG1        8'h14

`endif

// ==== hw/pkt_comm_pkg.sv ====
//--------------------------------------------------------------------
// Packet front end types shared by the parser, queues and APB block
//--------------------------------------------------------------------
package pkt_comm_pkg;

  typedef enum logic [7:0] {
    WORD_LIST  = 8'd1,
    CMP_CONFIG = 8'd3
  } pkt_type_e;

  // One entry of the input byte FIFO
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } in_byte_t;

  // Fields collected from the 8-byte header
  typedef struct packed {
    logic [7:0]  version;
    logic [7:0]  ptype;
    logic [15:0] len;
    logic [15:0] id;
  } hdr_t;

  typedef struct packed {
    logic err_version;
    logic err_type;
    logic err_len;
    logic err_checksum;
  } status_t;

  typedef struct packed {
    logic       valid;
    logic [2:0] idx;
    logic [7:0] data;
  } cfg_wr_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  // Raw word on the write side, byte view on the read side
  typedef union packed {
    logic [15:0] raw;
    byte_pair_t  bytes;
  } out_word_u;

  typedef struct packed {
    out_word_u word;
    logic      last;
  } res_word_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// ==== hw/pkt_comm_top.sv ====
//--------------------------------------------------------------------
// Packet front end top: input FIFO, parser, result queue, output
// serializer and APB registers
//--------------------------------------------------------------------
`timescale 1ns/100ps

module pkt_comm_top (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  logic [7:0]             s_tdata,
  input  logic                   s_tvalid,
  output logic                   s_tready,
  input  logic                   s_tlast,
  output logic [7:0]             m_tdata,
  output logic                   m_tvalid,
  input  logic                   m_tready,
  output logic                   m_tlast,
  input  pkt_comm_pkg::apb_req_t apb_req,
  output pkt_comm_pkg::apb_rsp_t apb_rsp,
  output logic                   error
);
  import pkt_comm_pkg::*;

  in_byte_t  fifo_head;
  logic      fifo_empty;
  logic      fifo_pop;

  res_word_t res_in;
  logic      res_push;
  logic      res_full;
  res_word_t res_head;
  logic      res_empty;
  logic      res_pop;

  cfg_wr_t   cfg_wr;
  status_t   err_set;
  logic      accept;

  pkt_byte_fifo i_pkt_byte_fifo (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .head     (fifo_head),
    .empty    (fifo_empty),
    .pop      (fifo_pop)
  );

  pkt_header_parser i_pkt_header_parser (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .head     (fifo_head),
    .empty    (fifo_empty),
    .pop      (fifo_pop),
    .res      (res_in),
    .res_push (res_push),
    .res_full (res_full),
    .cfg_wr   (cfg_wr),
    .err_set  (err_set),
    .accept   (accept)
  );

  pkt_result_queue i_pkt_result_queue (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .in_word (res_in),
    .push    (res_push),
    .full    (res_full),
    .head    (res_head),
    .empty   (res_empty),
    .pop     (res_pop)
  );

  stream16_to_axis8 i_stream16_to_axis8 (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .word     (res_head),
    .empty    (res_empty),
    .pop      (res_pop),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast)
  );

  pkt_apb_csr i_pkt_apb_csr (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .cfg_wr  (cfg_wr),
    .err_set (err_set),
    .accept  (accept),
    .error   (error)
  );

endmodule

// ==== hw/pkt_header_parser.sv ====
//--------------------------------------------------------------------
// Packet parser: checks the header, sums WORD_LIST payloads, issues
// configuration writes and pushes the id/sum result words
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_header_parser (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::in_byte_t  head,
  input  logic                    empty,
  output logic                    pop,
  output pkt_comm_pkg::res_word_t res,
  output logic                    res_push,
  input  logic                    res_full,
  output pkt_comm_pkg::cfg_wr_t   cfg_wr,
  output pkt_comm_pkg::status_t   err_set,
  output logic                    accept
);
  import pkt_comm_pkg::*;

  localparam int CNT_W = $clog2(`HDR_BYTES);
  localparam int LEN_W = $clog2(`PKT_LEN_MAX) + 1;
  localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(`HDR_BYTES - 1);

  typedef enum logic [1:0] {HEADER, PAYLOAD, RESULT, DISCARD} state_e;

  state_e           state;
  logic [CNT_W-1:0] hdr_cnt;
  logic [LEN_W-1:0] remaining;
  logic             res_phase;
  hdr_t             hdr;
  logic [7:0]       csum;
  logic [15:0]      sum;

  logic             hdr_end;
  logic             last_pay;
  logic             type_ok;
  logic             len_zero;
  logic             len_big;
  logic             stall;
  logic             pkt_done;
  logic [LEN_W-1:0] offset;

  assign hdr_end  = (state == HEADER) && (hdr_cnt == HDR_LAST);
  assign last_pay = (remaining == LEN_W'(1));
  assign type_ok  = (hdr.ptype == WORD_LIST) || (hdr.ptype == CMP_CONFIG);
  assign len_zero = (hdr.len == 16'd0);
  assign len_big  = (hdr.len > 16'(`PKT_LEN_MAX));
  assign offset   = hdr.len[LEN_W-1:0] - remaining;

  // Hold the final WORD_LIST byte until the queue has room
  assign stall = (state == PAYLOAD) && last_pay && (hdr.ptype == WORD_LIST) && res_full;
  assign pop   = !empty && (state != RESULT) && !stall;

  always_comb begin
    err_set = '0;
    if (pop) begin
      if (hdr_end) begin
        err_set.err_version  = (hdr.version != `PKT_VERSION);
        err_set.err_type     = !type_ok;
        err_set.err_len      = len_big || (head.last != len_zero);
        err_set.err_checksum = (head.data != csum);
      end else if (state == HEADER) begin
        err_set.err_len = head.last;
      end else if (state == PAYLOAD) begin
        // Early tlast or missing tlast
        err_set.err_len = (head.last != last_pay);
      end
    end
  end

  assign pkt_done = pop && !(|err_set) && ((hdr_end && len_zero) ||
                                           ((state == PAYLOAD) && last_pay));

  assign res_push      = (state == RESULT) && !res_full;
  assign res.word.raw  = res_phase ? sum : hdr.id;
  assign res.last      = res_phase;
  assign accept        = (pkt_done && (hdr.ptype == CMP_CONFIG)) || (res_push && res_phase);

  assign cfg_wr.valid = pop && (state == PAYLOAD) && (hdr.ptype == CMP_CONFIG) &&
                        (offset < LEN_W'(`CFG_BYTES));
  assign cfg_wr.idx   = offset[2:0];
  assign cfg_wr.data  = head.data;

  // Header fields and running sums
  always_ff @(posedge CLK) begin
    if (pop && state == HEADER) begin
      csum <= (hdr_cnt == '0) ? head.data : csum + head.data;
      case (hdr_cnt)
        3'd0: hdr.version   <= head.data;
        3'd1: hdr.ptype     <= head.data;
        3'd2: hdr.len[7:0]  <= head.data;
        3'd3: hdr.len[15:8] <= head.data;
        3'd4: hdr.id[7:0]   <= head.data;
        3'd5: hdr.id[15:8]  <= head.data;
        default: ;
      endcase
      sum <= '0;
    end else if (pop && state == PAYLOAD) begin
      sum <= sum + {8'h00, head.data};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state     <= HEADER;
      hdr_cnt   <= '0;
      remaining <= '0;
      res_phase <= 1'b0;
    end else begin
      case (state)
        HEADER: if (pop) begin
          hdr_cnt <= (hdr_end || head.last) ? '0 : hdr_cnt + 1'b1;
          if (hdr_end) begin
            remaining <= hdr.len[LEN_W-1:0];
            if (|err_set) state <= head.last ? HEADER : DISCARD;
            else if (pkt_done) state <= (hdr.ptype == WORD_LIST) ? RESULT : HEADER;
            else state <= PAYLOAD;
          end
        end
        PAYLOAD: if (pop) begin
          remaining <= remaining - 1'b1;
          if (|err_set) state <= head.last ? HEADER : DISCARD;
          else if (pkt_done) state <= (hdr.ptype == WORD_LIST) ? RESULT : HEADER;
        end
        RESULT: if (res_push) begin
          // Id word first, then the sum with the last flag
          res_phase <= ~res_phase;
          if (res_phase) state <= HEADER;
        end
        DISCARD: if (pop && head.last) state <= HEADER;
        default: state <= HEADER;
      endcase
    end
  end

endmodule

// ==== hw/pkt_result_queue.sv ====
//--------------------------------------------------------------------
// Result word FIFO between the parser and the output serializer
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_result_queue (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::res_word_t in_word,
  input  logic                    push,
  output logic                    full,
  output pkt_comm_pkg::res_word_t head,
  output logic                    empty,
  input  logic                    pop
);
  import pkt_comm_pkg::*;

  localparam int AW = $clog2(`OUT_QUEUE_DEPTH);

  res_word_t   mem [`OUT_QUEUE_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign head  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (push && !full) mem[wr_ptr[AW-1:0]] <= in_word;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== hw/stream16_to_axis8.sv ====
//--------------------------------------------------------------------
// 16-bit word to 8-bit AXI4-Stream serializer, low byte first
//--------------------------------------------------------------------
`timescale 1ns/100ps

module stream16_to_axis8 (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::res_word_t word,
  input  logic                    empty,
  output logic                    pop,
  output logic [7:0]              m_tdata,
  output logic                    m_tvalid,
  input  logic                    m_tready,
  output logic                    m_tlast
);
  import pkt_comm_pkg::*;

  res_word_t word_r;
  logic      vld;
  // 0 while the low byte is out, 1 for the high byte
  logic      phase;

  // Next word loads when idle or as the high byte leaves
  assign pop = !empty && (!vld || (phase && m_tready));

  always_ff @(posedge CLK) begin
    if (pop) word_r <= word;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      vld   <= 1'b0;
      phase <= 1'b0;
    end else if (pop) begin
      vld   <= 1'b1;
      phase <= 1'b0;
    end else if (vld && m_tready) begin
      if (!phase) phase <= 1'b1;
      else vld <= 1'b0;
    end
  end

  assign m_tdata  = phase ? word_r.word.bytes.hi : word_r.word.bytes.lo;
  assign m_tvalid = vld;
  assign m_tlast  = vld && phase && word_r.last;

endmodule

// ==== pkt_comm_top.f ====
+incdir+hw
hw/pkt_comm_pkg.sv
hw/pkt_byte_fifo.sv
hw/pkt_header_parser.sv
hw/pkt_apb_csr.sv
hw/pkt_result_queue.sv
hw/stream16_to_axis8.sv
hw/pkt_comm_top.sv
test/pkt_comm_props.sv
test/pkt_comm_tb.sv

// ==== test/pkt_comm_props.sv ====
//--------------------------------------------------------------------
// Protocol assertions for the packet front end, bound to the top
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_comm_props (
  input logic                            CLK,
  input logic                            RSTN,
  input logic [7:0]                      m_tdata,
  input logic                            m_tvalid,
  input logic                            m_tready,
  input logic                            m_tlast,
  input logic                            s_tvalid,
  input logic                            s_tready,
  input logic [$clog2(`IN_FIFO_DEPTH):0] fifo_wr_ptr,
  input logic [$clog2(`IN_FIFO_DEPTH):0] fifo_rd_ptr,
  input pkt_comm_pkg::apb_rsp_t          apb_rsp
);

  localparam int PW = $clog2(`IN_FIFO_DEPTH) + 1;

  // Bytes held in the input FIFO, from its pointers
  logic [PW-1:0] fifo_fill;

  assign fifo_fill = fifo_wr_ptr - fifo_rd_ptr;

  // Output byte held until the sink takes it
  a_tvalid_held: assert property (@(posedge CLK) disable iff (!RSTN)
    (m_tvalid && !m_tready) |=> m_tvalid)
    else $error("m_tvalid dropped before m_tready was seen");

  a_tdata_stable: assert property (@(posedge CLK) disable iff (!RSTN)
    (m_tvalid && !m_tready) |=> ($stable(m_tdata) && $stable(m_tlast)))
    else $error("m_tdata or m_tlast changed while stalled");

  a_no_push_full: assert property (@(posedge CLK) disable iff (!RSTN)
    (s_tvalid && s_tready) |-> (fifo_fill < PW'(`IN_FIFO_DEPTH)))
    else $error("byte FIFO accepted a byte while full");

  // No wait states on APB
  a_pready_high: assert property (@(posedge CLK) disable iff (!RSTN)
    apb_rsp.pready)
    else $error("pready went low");

endmodule

bind pkt_comm_top pkt_comm_props i_pkt_comm_props (
  .CLK         (CLK),
  .RSTN        (RSTN),
  .m_tdata     (m_tdata),
  .m_tvalid    (m_tvalid),
  .m_tready    (m_tready),
  .m_tlast     (m_tlast),
  .s_tvalid    (s_tvalid),
  .s_tready    (s_tready),
  .fifo_wr_ptr (i_pkt_byte_fifo.wr_ptr),
  .fifo_rd_ptr (i_pkt_byte_fifo.rd_ptr),
  .apb_rsp     (apb_rsp)
);

// ==== test/pkt_comm_tb.sv ====
//--------------------------------------------------------------------
// Testbench for the packet front end: packet stimulus, APB checks,
// reference result model and output stream compare
//--------------------------------------------------------------------
`timescale 1ns/100ps

`include "pkt_comm_config.svh"

module pkt_comm_tb;
  import pkt_comm_pkg::*;

  logic       CLK;
  logic       RSTN;
  logic [7:0] s_tdata;
  logic       s_tvalid;
  logic       s_tready;
  logic       s_tlast;
  logic [7:0] m_tdata;
  logic       m_tvalid;
  logic       m_tready;
  logic       m_tlast;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  logic       error;

  int         seed = 58610;
  int         ready_seed = 58610;
  logic       rand_ready = 1'b0;
  logic       hold_ready = 1'b0;
  int         cycles = 0;
  int         n_stim = 0;
  int         accepted = 0;
  logic [7:0] payload[$];
  in_byte_t   exp_q[$];

  pkt_comm_top i_pkt_comm_top (
    .CLK      (CLK),
    .RSTN     (RSTN),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .error    (error)
  );

  always #50 CLK = ~CLK;

  task automatic fail_now(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_byte(input in_byte_t got, input in_byte_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: %s got %h last %b, expected %h last %b",
                         $time, what, got.data, got.last, exp.data, exp.last));
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: STATUS got %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Id in the low half, payload sum modulo 2^16 in the high half
  function automatic logic [31:0] ref_result(input logic [15:0] id, input logic [7:0] bytes_in[$]);
    logic [15:0] s;
    s = '0;
    foreach (bytes_in[i]) s = s + {8'h00, bytes_in[i]};
    return {s, id};
  endfunction

  // Sink readiness, random once enabled, forced low while held
  always @(posedge CLK) begin : drive_ready
    logic [31:0] rnd;
    #10;
    rnd = $random(ready_seed);
    m_tready = hold_ready ? 1'b0 : (rand_ready ? rnd[0] : 1'b1);
  end

  // Transfer happens at the next rising edge, values are stable here
  always @(negedge CLK) begin : compare_out
    in_byte_t got;
    got.data = m_tdata;
    got.last = m_tlast;
    if (RSTN && m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("Unexpected output byte %h at time %0t", m_tdata, $time));
      end else begin
        check_byte(got, exp_q.pop_front(), "output byte");
      end
    end
  end

  always @(posedge CLK) begin : watchdog
    cycles = cycles + 1;
    if (cycles > 40 * n_stim + 500) begin
      fail_now($sformatf("Timeout: no progress after %0d cycles", cycles));
    end
  end

  task automatic send_byte(input logic [7:0] data, input logic last);
    logic ok;
    ok = 1'b0;
    s_tdata  = data;
    s_tlast  = last;
    s_tvalid = 1'b1;
    while (!ok) begin
      ok = s_tready;
      @(posedge CLK);
      #10;
    end
    s_tvalid = 1'b0;
    n_stim = n_stim + 1;
  endtask

  // Header plus payload, tlast on byte stop-1 when stop is given
  task automatic send_packet(input logic [7:0] ver, input logic [7:0] ptype,
                             input logic [15:0] id, input logic bad_sum, input int stop);
    logic [7:0]  hdr[8];
    logic [15:0] len;
    logic [7:0]  csum;
    int          total;
    len = 16'(payload.size());
    hdr[0] = ver;
    hdr[1] = ptype;
    hdr[2] = len[7:0];
    hdr[3] = len[15:8];
    hdr[4] = id[7:0];
    hdr[5] = id[15:8];
    hdr[6] = 8'h00;
    csum = '0;
    for (int i = 0; i < 7; i++) csum = csum + hdr[i];
    hdr[7] = bad_sum ? ~csum : csum;
    total = (stop > 0) ? stop : 8 + payload.size();
    for (int i = 0; i < total; i++) begin
      send_byte((i < 8) ? hdr[i] : payload[i-8], i == total - 1);
    end
  endtask

  task automatic make_payload(input int n);
    logic [31:0] r;
    payload.delete();
    repeat (n) begin
      r = $random(seed);
      payload.push_back(r[7:0]);
    end
  endtask

  task automatic push_exp(input logic [7:0] data, input logic last);
    in_byte_t b;
    b.data = data;
    b.last = last;
    exp_q.push_back(b);
  endtask

  task automatic send_word_list(input int n, input logic [15:0] id);
    logic [31:0] ref_val;
    make_payload(n);
    ref_val = ref_result(id, payload);
    push_exp(ref_val[7:0], 1'b0);
    push_exp(ref_val[15:8], 1'b0);
    push_exp(ref_val[23:16], 1'b0);
    push_exp(ref_val[31:24], 1'b1);
    send_packet(`PKT_VERSION, WORD_LIST, id, 1'b0, 0);
    accepted = accepted + 1;
  endtask

  task automatic wait_drain;
    while (exp_q.size() != 0) begin
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge CLK);
    #10;
    apb_req.penable = 1'b1;
    @(negedge CLK);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge CLK);
    #10;
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_access(1'b0, addr, 32'd0, rdata, slverr);
    check_word(32'(slverr), 32'd0, "pslverr on mapped read");
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rd, slverr);
    check_word(32'(slverr), 32'd0, "pslverr on mapped write");
  endtask

  task automatic wait_count(input int expected);
    logic [31:0] rd;
    rd = '0;
    while (rd != 32'(expected)) apb_read(`REG_COUNT, rd);
  endtask

  // Bad packet, status check and clear, then a good packet behind it
  task automatic error_case(input logic [7:0] ver, input logic [7:0] ptype, input logic bad_sum,
                            input int stop, input status_t exp, input logic [15:0] id);
    logic [31:0] rd;
    make_payload(6);
    send_packet(ver, ptype, id, bad_sum, stop);
    while (!error) begin
      @(posedge CLK);
      #10;
    end
    apb_read(`REG_STATUS, rd);
    check_status(status_t'(rd[3:0]), exp);
    apb_write(`REG_STATUS, 32'h0000_000f);
    apb_read(`REG_STATUS, rd);
    check_status(status_t'(rd[3:0]), '0);
    check_word(32'(error), 32'd0, "error after clear");
    send_word_list(5, id + 16'd1);
    wait_drain;
    apb_read(`REG_COUNT, rd);
    check_word(rd, 32'(accepted), "COUNT");
  endtask

  initial begin : main
    logic [31:0] rd;
    logic [31:0] r;
    logic        slverr;
    logic [7:0]  cfg_exp[$];
    CLK      = 1'b0;
    RSTN     = 1'b0;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    m_tready = 1'b0;
    apb_req  = '0;
    repeat (4) @(posedge CLK);
    #10;
    RSTN = 1'b1;

    check_word(32'(m_tvalid), 32'd0, "m_tvalid after reset");
    check_word(32'(error), 32'd0, "error after reset");
    apb_read(`REG_STATUS, rd);
    check_status(status_t'(rd[3:0]), '0);
    apb_read(`REG_COUNT, rd);
    check_word(rd, 32'd0, "COUNT after reset");

    // WORD_LIST packets, empty payload first, random sink later
    send_word_list(0, 16'hA500);
    for (int k = 1; k < 8; k++) begin
      rand_ready = (k >= 4);
      r = $random(seed);
      send_word_list(int'(r % 32'd21), 16'hA500 + 16'(k));
    end

    // Stalled sink fills the result queue, then the byte FIFO
    hold_ready = 1'b1;
    fork
      for (int k = 0; k < 8; k++) send_word_list(20, 16'hC000 + 16'(k));
      begin
        repeat (300) @(posedge CLK);
        hold_ready = 1'b0;
      end
    join
    wait_drain;
    apb_read(`REG_COUNT, rd);
    check_word(rd, 32'(accepted), "COUNT after WORD_LIST");

    // CMP_CONFIG, bytes past the eighth are dropped
    make_payload(10);
    cfg_exp = payload;
    send_packet(`PKT_VERSION, CMP_CONFIG, 16'h00C3, 1'b0, 0);
    accepted = accepted + 1;
    wait_count(accepted);
    apb_read(`REG_CFG0, rd);
    check_word(rd, {cfg_exp[3], cfg_exp[2], cfg_exp[1], cfg_exp[0]}, "CFG0");
    apb_read(`REG_CFG1, rd);
    check_word(rd, {cfg_exp[7], cfg_exp[6], cfg_exp[5], cfg_exp[4]}, "CFG1");

    // Status bits: version, type, len, checksum from MSB down
    error_case(8'd3, WORD_LIST, 1'b0, 0, status_t'(4'b1000), 16'hB000);
    error_case(`PKT_VERSION, 8'd2, 1'b0, 0, status_t'(4'b0100), 16'hB100);
    error_case(`PKT_VERSION, WORD_LIST, 1'b1, 0, status_t'(4'b0001), 16'hB200);
    error_case(`PKT_VERSION, WORD_LIST, 1'b0, 11, status_t'(4'b0010), 16'hB300);

    apb_access(1'b0, 8'h08, 32'd0, rd, slverr);
    check_word(32'(slverr), 32'd1, "pslverr on unmapped read");

    $display("** PASS **");
    $finish;
  end

endmodule
